// ==== Makefile ====
# Verilator flow for the L1 data cache memory block

VERILATOR  ?= verilator
TOP        := l1_dcache_mem_tb
FILELIST   := l1_dcache_mem.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the simulator's exit status carries pass or fail
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== dcache_bank_ctrl.sv ====
/*
 * Request, write enable and index generation for the data banks and the
 * tag array. A refill owns all banks; otherwise a read and a word write
 * share the banks when their word offsets differ.
 */

`timescale 1ns/1ps
`default_nettype none

module dcache_bank_ctrl import dcache_mem_pkg::*; (
  input  wire logic                      rd_acked_i,
  input  wire logic [PORT_SEL_WIDTH-1:0] rd_sel_i,
  input  rd_req_t   [NUM_RD_PORTS-1:0]   rd_req_data_i,
  input  wire logic                      cl_wr_vld_i,
  input  cl_wr_t                         cl_wr_i,
  input  wire logic [NUM_WAYS-1:0]       wr_req_i,
  input  word_wr_t                       wr_data_i,
  output logic                           wr_ack_o,
  output logic [NUM_BANKS-1:0]           bank_req_o,
  output logic [NUM_BANKS-1:0][NUM_WAYS-1:0] bank_we_o,
  output logic [NUM_BANKS-1:0][IDX_WIDTH-1:0] bank_idx_o,
  output word_t [NUM_BANKS-1:0][NUM_WAYS-1:0] bank_wdata_o,
  output logic                           tag_req_o,
  output logic [NUM_WAYS-1:0]            tag_we_o,
  output logic [IDX_WIDTH-1:0]           tag_addr_o,
  output tag_entry_t [NUM_WAYS-1:0]      tag_wdata_o
);

  rd_req_t                   rd_req;
  logic [BANK_SEL_WIDTH-1:0] rd_bank;
  logic [BANK_SEL_WIDTH-1:0] wr_bank;
  logic                      bank_collision;

  assign rd_req  = rd_req_data_i[rd_sel_i];
  assign rd_bank = rd_req.off[OFF_WIDTH-1:BYTE_OFF_WIDTH];
  assign wr_bank = wr_data_i.off[OFF_WIDTH-1:BYTE_OFF_WIDTH];

  assign bank_collision = rd_acked_i && (rd_bank == wr_bank);
  assign wr_ack_o       = (|wr_req_i) && !cl_wr_vld_i && !bank_collision;

  ////////////////////////////////////////
  // write data
  ////////////////////////////////////////

  for (genvar k = 0; k < NUM_BANKS; k++) begin : gen_bank_wdata
    for (genvar j = 0; j < NUM_WAYS; j++) begin : gen_way_wdata
      assign bank_wdata_o[k][j] = cl_wr_vld_i ? cl_wr_i.data[k] : wr_data_i.data;
    end
  end

  for (genvar j = 0; j < NUM_WAYS; j++) begin : gen_tag_wdata
    assign tag_wdata_o[j].valid = cl_wr_i.vld_bits[j];
    assign tag_wdata_o[j].tag   = cl_wr_i.tag;
  end

  ////////////////////////////////////////
  // bank and tag requests
  ////////////////////////////////////////

  always_comb begin
    bank_req_o = '0;
    bank_we_o  = '0;
    // idle banks point at the word write index
    for (int k = 0; k < NUM_BANKS; k++) begin
      bank_idx_o[k] = wr_data_i.idx;
    end
    tag_req_o  = 1'b0;
    tag_we_o   = '0;
    tag_addr_o = rd_req.idx;

    if (cl_wr_vld_i) begin
      // whole line into the masked ways
      bank_req_o = '1;
      for (int k = 0; k < NUM_BANKS; k++) begin
        bank_we_o[k]  = cl_wr_i.way_we;
        bank_idx_o[k] = cl_wr_i.idx;
      end
      tag_req_o  = 1'b1;
      tag_we_o   = cl_wr_i.way_we;
      tag_addr_o = cl_wr_i.idx;
    end else begin
      if (rd_acked_i) begin
        bank_req_o[rd_bank] = 1'b1;
        bank_idx_o[rd_bank] = rd_req.idx;
        tag_req_o           = 1'b1;
      end
      if (wr_ack_o) begin
        bank_req_o[wr_bank] = 1'b1;
        bank_we_o[wr_bank]  = wr_req_i;
      end
    end
  end

endmodule

`default_nettype wire

// ==== dcache_mem_pkg.sv ====
/*
 * Shared geometry, address fields and port structs of the L1 data cache
 * memory block. Every module of the block imports this package.
 */

`default_nettype none

package dcache_mem_pkg;

  ////////////////////////////////////////
  // geometry
  ////////////////////////////////////////

  localparam int unsigned XLEN         = 32;
  localparam int unsigned NUM_WAYS     = 2;
  localparam int unsigned NUM_SETS     = 16;
  // one sram bank per word offset
  localparam int unsigned NUM_BANKS    = 4;
  localparam int unsigned NUM_RD_PORTS = 2;

  ////////////////////////////////////////
  // address fields
  ////////////////////////////////////////

  localparam int unsigned TAG_WIDTH      = 8;
  localparam int unsigned IDX_WIDTH      = $clog2(NUM_SETS);
  localparam int unsigned BYTE_OFF_WIDTH = $clog2(XLEN / 8);
  localparam int unsigned BANK_SEL_WIDTH = $clog2(NUM_BANKS);
  localparam int unsigned OFF_WIDTH      = BANK_SEL_WIDTH + BYTE_OFF_WIDTH;
  localparam int unsigned PORT_SEL_WIDTH = $clog2(NUM_RD_PORTS);

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////

  typedef logic [XLEN-1:0] word_t;

  // payload of the tag arrays, one per way
  typedef struct packed {
    logic                 valid;
    logic [TAG_WIDTH-1:0] tag;
  } tag_entry_t;

  typedef struct packed {
    logic [IDX_WIDTH-1:0] idx;
    logic [OFF_WIDTH-1:0] off;
    logic                 prio;  // 1: high priority
  } rd_req_t;

  // full cacheline refill
  typedef struct packed {
    logic [NUM_WAYS-1:0]         way_we;
    logic [TAG_WIDTH-1:0]        tag;
    logic [IDX_WIDTH-1:0]        idx;
    logic [NUM_WAYS-1:0]         vld_bits;
    word_t [NUM_BANKS-1:0]       data;
  } cl_wr_t;

  // single word write, way select is the request vector
  typedef struct packed {
    logic [IDX_WIDTH-1:0] idx;
    logic [OFF_WIDTH-1:0] off;
    word_t                data;
  } word_wr_t;

endpackage

`default_nettype wire

// ==== dcache_rd_arbiter.sv ====
/*
 * Read port arbiter. High priority requests mask low priority ones,
 * the rest are granted round robin. No grant is given in a refill cycle.
 */

`timescale 1ns/1ps
`default_nettype none

module dcache_rd_arbiter import dcache_mem_pkg::*; (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic [NUM_RD_PORTS-1:0]   rd_req_i,
  input  wire logic [NUM_RD_PORTS-1:0]   rd_prio_i,
  input  wire logic                      cl_wr_vld_i,
  output logic      [NUM_RD_PORTS-1:0]   rd_ack_o,
  output logic                           rd_acked_o,
  output logic      [PORT_SEL_WIDTH-1:0] rd_sel_o
);

  logic [NUM_RD_PORTS-1:0]   req_prio;
  logic [NUM_RD_PORTS-1:0]   req_masked;
  logic                      req_found;
  logic [PORT_SEL_WIDTH-1:0] rr_d;
  logic [PORT_SEL_WIDTH-1:0] rr_q;

  ////////////////////////////////////////
  // priority masking
  ////////////////////////////////////////

  assign req_prio   = rd_req_i & rd_prio_i;
  assign req_masked = (|req_prio) ? req_prio : rd_req_i;

  ////////////////////////////////////////
  // round robin search
  ////////////////////////////////////////

  // first requesting port at or after the pointer
  always_comb begin
    int unsigned idx;
    req_found = 1'b0;
    rd_sel_o  = rr_q;
    for (int i = 0; i < NUM_RD_PORTS; i++) begin
      idx = (int'(rr_q) + i) % NUM_RD_PORTS;
      if (!req_found && req_masked[idx]) begin
        req_found = 1'b1;
        rd_sel_o  = PORT_SEL_WIDTH'(idx);
      end
    end
  end

  // a refill blocks every read in its cycle
  assign rd_acked_o = req_found & ~cl_wr_vld_i;

  always_comb begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      rd_ack_o[p] = rd_acked_o && (rd_sel_o == PORT_SEL_WIDTH'(p));
    end
  end

  // pointer moves past the port that took its grant
  assign rr_d = PORT_SEL_WIDTH'((int'(rd_sel_o) + 1) % NUM_RD_PORTS);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (rd_acked_o) begin
      rr_q <= rr_d;
    end
  end

endmodule

`default_nettype wire

// ==== dcache_sram.sv ====
/*
 * Single-port synchronous array with one write enable per lane.
 * A request with any lane enabled writes, otherwise it reads.
 * Used for the data banks and for the tag array.
 */

`timescale 1ns/1ps
`default_nettype none

module dcache_sram import dcache_mem_pkg::*; #(
  parameter type         lane_t   = word_t,
  parameter int unsigned NumLanes = NUM_WAYS
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  req_i,
  input  wire logic [NumLanes-1:0]   lane_we_i,
  input  wire logic [IDX_WIDTH-1:0]  addr_i,
  input  lane_t     [NumLanes-1:0]   wdata_i,
  output lane_t     [NumLanes-1:0]   rdata_o
);

  lane_t [NumLanes-1:0] mem_q [NUM_SETS];

  // write port, only the enabled lanes change
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      for (int l = 0; l < NumLanes; l++) begin
        if (lane_we_i[l]) begin
          mem_q[addr_i][l] <= wdata_i[l];
        end
      end
    end
  end

  // registered read data, held until the next read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i && !(|lane_we_i)) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

`default_nettype wire

// ==== dcache_tag_cmp.sv ====
/*
 * Lookup stage. Registers the accepted read, then compares the late tag
 * of that port with every valid way and selects the hitting word.
 * Results are valid one cycle after the read acknowledge.
 */

`timescale 1ns/1ps
`default_nettype none

module dcache_tag_cmp import dcache_mem_pkg::*; (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  input  wire logic                                  lookup_i,
  input  wire logic [PORT_SEL_WIDTH-1:0]             rd_sel_i,
  input  wire logic [BANK_SEL_WIDTH-1:0]             bank_sel_i,
  input  wire logic [NUM_RD_PORTS-1:0][TAG_WIDTH-1:0] rd_tag_i,
  input  tag_entry_t [NUM_WAYS-1:0]                  tag_rdata_i,
  input  word_t [NUM_BANKS-1:0][NUM_WAYS-1:0]        bank_rdata_i,
  output logic [NUM_WAYS-1:0]                        rd_hit_oh_o,
  output logic [NUM_WAYS-1:0]                        rd_vld_bits_o,
  output word_t                                      rd_data_o
);

  logic                      lookup_q;
  logic [PORT_SEL_WIDTH-1:0] rd_sel_q;
  logic [BANK_SEL_WIDTH-1:0] bank_sel_q;
  logic [TAG_WIDTH-1:0]      rd_tag;
  word_t [NUM_WAYS-1:0]      way_word;

  ////////////////////////////////////////
  // pipeline registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lookup_q   <= 1'b0;
      rd_sel_q   <= '0;
      bank_sel_q <= '0;
    end else begin
      lookup_q <= lookup_i;
      if (lookup_i) begin
        rd_sel_q   <= rd_sel_i;
        bank_sel_q <= bank_sel_i;
      end
    end
  end

  ////////////////////////////////////////
  // compare and word select
  ////////////////////////////////////////

  // the tag arrives one cycle after the acknowledge
  assign rd_tag = rd_tag_i[rd_sel_q];

  for (genvar j = 0; j < NUM_WAYS; j++) begin : gen_way_cmp
    assign rd_vld_bits_o[j] = tag_rdata_i[j].valid;
    assign rd_hit_oh_o[j]   = lookup_q && tag_rdata_i[j].valid &&
                              (tag_rdata_i[j].tag == rd_tag);
    assign way_word[j]      = bank_rdata_i[bank_sel_q][j];
  end

  // and-or mux, zero on a miss
  always_comb begin
    rd_data_o = '0;
    for (int j = 0; j < NUM_WAYS; j++) begin
      if (rd_hit_oh_o[j]) begin
        rd_data_o = rd_data_o | way_word[j];
      end
    end
  end

endmodule

`default_nettype wire

// ==== l1_dcache_mem.f ====
dcache_mem_pkg.sv
dcache_sram.sv
dcache_rd_arbiter.sv
dcache_bank_ctrl.sv
dcache_tag_cmp.sv
l1_dcache_mem.sv
l1_dcache_mem_sva.sv
l1_dcache_mem_tb.sv

// ==== l1_dcache_mem.sv ====
/*
 * Memory block of the write-through L1 data cache: two read ports,
 * a full line refill port and a single word write port.
 * Reads return hit vector and word one cycle after rd_ack_o.
 */

`timescale 1ns/1ps
`default_nettype none

module l1_dcache_mem import dcache_mem_pkg::*; (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  // read ports
  input  wire logic [NUM_RD_PORTS-1:0]               rd_req_i,
  input  rd_req_t   [NUM_RD_PORTS-1:0]               rd_req_data_i,
  input  wire logic [NUM_RD_PORTS-1:0][TAG_WIDTH-1:0] rd_tag_i,
  output logic      [NUM_RD_PORTS-1:0]               rd_ack_o,
  output logic      [NUM_WAYS-1:0]                   rd_hit_oh_o,
  output logic      [NUM_WAYS-1:0]                   rd_vld_bits_o,
  output word_t                                      rd_data_o,
  // refill strobe
  input  wire logic                                  cl_wr_vld_i,
  input  cl_wr_t                                     cl_wr_i,
  // word write
  input  wire logic [NUM_WAYS-1:0]                   wr_req_i,
  input  word_wr_t                                   wr_data_i,
  output logic                                       wr_ack_o
);

  logic [NUM_RD_PORTS-1:0]              rd_prio;
  logic                                 rd_acked;
  logic [PORT_SEL_WIDTH-1:0]            rd_sel;
  logic [BANK_SEL_WIDTH-1:0]            rd_bank_sel;

  logic [NUM_BANKS-1:0]                 bank_req;
  logic [NUM_BANKS-1:0][NUM_WAYS-1:0]   bank_we;
  logic [NUM_BANKS-1:0][IDX_WIDTH-1:0]  bank_idx;
  word_t [NUM_BANKS-1:0][NUM_WAYS-1:0]  bank_wdata;
  word_t [NUM_BANKS-1:0][NUM_WAYS-1:0]  bank_rdata;

  logic                                 tag_req;
  logic [NUM_WAYS-1:0]                  tag_we;
  logic [IDX_WIDTH-1:0]                 tag_addr;
  tag_entry_t [NUM_WAYS-1:0]            tag_wdata;
  tag_entry_t [NUM_WAYS-1:0]            tag_rdata;

  for (genvar p = 0; p < NUM_RD_PORTS; p++) begin : gen_prio
    assign rd_prio[p] = rd_req_data_i[p].prio;
  end

  // word offset of the granted port, used by the compare stage
  assign rd_bank_sel = rd_req_data_i[rd_sel].off[OFF_WIDTH-1:BYTE_OFF_WIDTH];

  ////////////////////////////////////////
  // arbitration and bank control
  ////////////////////////////////////////

  dcache_rd_arbiter rd_arbiter_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_req_i    (rd_req_i),
    .rd_prio_i   (rd_prio),
    .cl_wr_vld_i (cl_wr_vld_i),
    .rd_ack_o    (rd_ack_o),
    .rd_acked_o  (rd_acked),
    .rd_sel_o    (rd_sel)
  );

  dcache_bank_ctrl bank_ctrl_inst (
    .rd_acked_i    (rd_acked),
    .rd_sel_i      (rd_sel),
    .rd_req_data_i (rd_req_data_i),
    .cl_wr_vld_i   (cl_wr_vld_i),
    .cl_wr_i       (cl_wr_i),
    .wr_req_i      (wr_req_i),
    .wr_data_i     (wr_data_i),
    .wr_ack_o      (wr_ack_o),
    .bank_req_o    (bank_req),
    .bank_we_o     (bank_we),
    .bank_idx_o    (bank_idx),
    .bank_wdata_o  (bank_wdata),
    .tag_req_o     (tag_req),
    .tag_we_o      (tag_we),
    .tag_addr_o    (tag_addr),
    .tag_wdata_o   (tag_wdata)
  );

  ////////////////////////////////////////
  // arrays
  ////////////////////////////////////////

  // valid bit and tag of all ways at one index
  dcache_sram #(
    .lane_t   (tag_entry_t),
    .NumLanes (NUM_WAYS)
  ) tag_sram_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (tag_req),
    .lane_we_i (tag_we),
    .addr_i    (tag_addr),
    .wdata_i   (tag_wdata),
    .rdata_o   (tag_rdata)
  );

  for (genvar k = 0; k < NUM_BANKS; k++) begin : gen_data_bank
    dcache_sram #(
      .lane_t   (word_t),
      .NumLanes (NUM_WAYS)
    ) data_sram_inst (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .req_i     (bank_req[k]),
      .lane_we_i (bank_we[k]),
      .addr_i    (bank_idx[k]),
      .wdata_i   (bank_wdata[k]),
      .rdata_o   (bank_rdata[k])
    );
  end

  ////////////////////////////////////////
  // compare stage
  ////////////////////////////////////////

  dcache_tag_cmp tag_cmp_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_i      (rd_acked),
    .rd_sel_i      (rd_sel),
    .bank_sel_i    (rd_bank_sel),
    .rd_tag_i      (rd_tag_i),
    .tag_rdata_i   (tag_rdata),
    .bank_rdata_i  (bank_rdata),
    .rd_hit_oh_o   (rd_hit_oh_o),
    .rd_vld_bits_o (rd_vld_bits_o),
    .rd_data_o     (rd_data_o)
  );

endmodule

`default_nettype wire

// ==== l1_dcache_mem_sva.sv ====
/*
 * Concurrent checks on the read and write handshakes of the cache memory.
 * Bound into every l1_dcache_mem instance by the bind at the end.
 */

`timescale 1ns/1ps
`default_nettype none

module l1_dcache_mem_sva import dcache_mem_pkg::*; (
  input wire logic                    clk_i,
  input wire logic                    rst_ni,
  input wire logic [NUM_RD_PORTS-1:0] rd_ack_i,
  input wire logic [NUM_WAYS-1:0]     rd_hit_oh_i,
  input wire logic                    cl_wr_vld_i,
  input wire logic [NUM_WAYS-1:0]     wr_req_i,
  input wire logic                    wr_ack_i
);

  ////////////////////////////////////////
  // read side
  ////////////////////////////////////////

  hit_onehot0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(rd_hit_oh_i))
    else $error("read hit vector has more than one way set");

  ack_onehot0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(rd_ack_i))
    else $error("more than one read port acknowledged");

  // refill owns the arrays for its cycle
  no_ack_in_refill: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cl_wr_vld_i |-> (rd_ack_i == '0) && !wr_ack_i)
    else $error("acknowledge given during a refill");

  ////////////////////////////////////////
  // word write side
  ////////////////////////////////////////

  wr_way_onehot0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_ack_i |-> $onehot0(wr_req_i))
    else $error("word write acknowledged with more than one way selected");

endmodule

bind l1_dcache_mem l1_dcache_mem_sva l1_dcache_mem_sva_inst (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .rd_ack_i    (rd_ack_o),
  .rd_hit_oh_i (rd_hit_oh_o),
  .cl_wr_vld_i (cl_wr_vld_i),
  .wr_req_i    (wr_req_i),
  .wr_ack_i    (wr_ack_o)
);

`default_nettype wire

// ==== l1_dcache_mem_tb.sv ====
/*
 * Testbench of the L1 data cache memory block. Drives refills, reads and
 * word writes, keeps a model of tags, valid bits and data, and checks every
 * read result one cycle after its acknowledge. Run from the file list.
 */

`timescale 1ns/1ps
`default_nettype none

module l1_dcache_mem_tb import dcache_mem_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 50;

  typedef struct packed {
    logic [NUM_WAYS-1:0] hit;
    logic [NUM_WAYS-1:0] vld;
    word_t               data;
  } exp_t;

  typedef struct packed {
    logic [PORT_SEL_WIDTH-1:0] port;
    logic [TAG_WIDTH-1:0]      tag;
    exp_t                      exp;
  } pend_t;

  logic                                   clk_i;
  logic                                   rst_ni;
  logic [NUM_RD_PORTS-1:0]                rd_req_i;
  rd_req_t [NUM_RD_PORTS-1:0]             rd_req_data_i;
  logic [NUM_RD_PORTS-1:0][TAG_WIDTH-1:0] rd_tag_i;
  logic [NUM_RD_PORTS-1:0]                rd_ack_o;
  logic [NUM_WAYS-1:0]                    rd_hit_oh_o;
  logic [NUM_WAYS-1:0]                    rd_vld_bits_o;
  word_t                                  rd_data_o;
  logic                                   cl_wr_vld_i;
  cl_wr_t                                 cl_wr_i;
  logic [NUM_WAYS-1:0]                    wr_req_i;
  word_wr_t                               wr_data_i;
  logic                                   wr_ack_o;

  // reference model of the arrays
  logic [TAG_WIDTH-1:0] m_tag  [NUM_WAYS][NUM_SETS];
  logic                 m_vld  [NUM_WAYS][NUM_SETS];
  word_t                m_data [NUM_WAYS][NUM_SETS][NUM_BANKS];

  logic [NUM_RD_PORTS-1:0][TAG_WIDTH-1:0] tag_of_port;
  pend_t pend_q[$];
  int    grant_log[$];
  int    rd_ack_at[NUM_RD_PORTS];
  int    wr_ack_at;
  int    n_checked = 0;

  always begin
    clk_i = 1'b0;
    #50;
    clk_i = 1'b1;
    #50;
  end

  l1_dcache_mem l1_dcache_mem_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_req_i      (rd_req_i),
    .rd_req_data_i (rd_req_data_i),
    .rd_tag_i      (rd_tag_i),
    .rd_ack_o      (rd_ack_o),
    .rd_hit_oh_o   (rd_hit_oh_o),
    .rd_vld_bits_o (rd_vld_bits_o),
    .rd_data_o     (rd_data_o),
    .cl_wr_vld_i   (cl_wr_vld_i),
    .cl_wr_i       (cl_wr_i),
    .wr_req_i      (wr_req_i),
    .wr_data_i     (wr_data_i),
    .wr_ack_o      (wr_ack_o)
  );

  ////////////////////////////////////////
  // reporting and reference
  ////////////////////////////////////////

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
      stop_with_failure("output value mismatch");
    end
  endtask

  // hit vector, valid bits and word a read of this line must return
  function automatic exp_t ref_lookup(input logic [IDX_WIDTH-1:0] idx,
                                      input logic [OFF_WIDTH-1:0] off,
                                      input logic [TAG_WIDTH-1:0] tag);
    exp_t                      e;
    logic [BANK_SEL_WIDTH-1:0] bank;
    e    = '0;
    bank = off[OFF_WIDTH-1:BYTE_OFF_WIDTH];
    for (int w = 0; w < NUM_WAYS; w++) begin
      e.vld[w] = m_vld[w][idx];
      if (m_vld[w][idx] && (m_tag[w][idx] == tag)) begin
        e.hit[w] = 1'b1;
        e.data   = e.data | m_data[w][idx][bank];
      end
    end
    return e;
  endfunction

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  task automatic set_read(input int p, input int idx, input int bank,
                          input logic [TAG_WIDTH-1:0] tag, input logic prio);
    rd_req_data_i[p].idx  = IDX_WIDTH'(idx);
    rd_req_data_i[p].off  = {BANK_SEL_WIDTH'(bank), {BYTE_OFF_WIDTH{1'b0}}};
    rd_req_data_i[p].prio = prio;
    tag_of_port[p]        = tag;
    rd_req_i[p]           = 1'b1;
  endtask

  task automatic set_word_write(input int way, input int idx, input int bank, input word_t data);
    wr_req_i       = '0;
    wr_req_i[way]  = 1'b1;
    wr_data_i.idx  = IDX_WIDTH'(idx);
    wr_data_i.off  = {BANK_SEL_WIDTH'(bank), {BYTE_OFF_WIDTH{1'b0}}};
    wr_data_i.data = data;
  endtask

  task automatic set_refill(input logic [NUM_WAYS-1:0] way_we, input logic [TAG_WIDTH-1:0] tag,
                            input int idx, input logic [NUM_WAYS-1:0] vld_bits);
    cl_wr_i.way_we   = way_we;
    cl_wr_i.tag      = tag;
    cl_wr_i.idx      = IDX_WIDTH'(idx);
    cl_wr_i.vld_bits = vld_bits;
    for (int b = 0; b < NUM_BANKS; b++) begin
      cl_wr_i.data[b] = $urandom();
    end
    cl_wr_vld_i = 1'b1;
  endtask

  // one cycle per pass until every driven request is acknowledged
  task automatic run_requests();
    logic [NUM_RD_PORTS-1:0] rd_took;
    logic                    wr_took;
    pend_t                   e;
    int                      cyc;
    cyc = 0;
    while ((|rd_req_i) || (|wr_req_i) || cl_wr_vld_i) begin
      if (cyc >= TIMEOUT_CYCLES) begin
        stop_with_failure("timeout while waiting for a read or write acknowledge");
      end
      #1;
      rd_took = rd_ack_o;
      wr_took = wr_ack_o;
      check_val("rd_ack_o without request", 32'(rd_took & ~rd_req_i), 32'd0);
      if (cl_wr_vld_i) begin
        check_val("rd_ack_o in refill cycle", 32'(rd_took), 32'd0);
        check_val("wr_ack_o in refill cycle", 32'(wr_took), 32'd0);
        for (int w = 0; w < NUM_WAYS; w++) begin
          if (cl_wr_i.way_we[w]) begin
            m_tag[w][cl_wr_i.idx] = cl_wr_i.tag;
            m_vld[w][cl_wr_i.idx] = cl_wr_i.vld_bits[w];
            for (int b = 0; b < NUM_BANKS; b++) begin
              m_data[w][cl_wr_i.idx][b] = cl_wr_i.data[b];
            end
          end
        end
      end else if (|rd_req_i) begin
        check_val("rd_ack_o ones count", 32'($countones(rd_took)), 32'd1);
      end
      for (int p = 0; p < NUM_RD_PORTS; p++) begin
        if (rd_took[p]) begin
          e.port = PORT_SEL_WIDTH'(p);
          e.tag  = tag_of_port[p];
          e.exp  = ref_lookup(rd_req_data_i[p].idx, rd_req_data_i[p].off, tag_of_port[p]);
          pend_q.push_back(e);
          grant_log.push_back(p);
          rd_ack_at[p] = cyc;
        end
      end
      if (wr_took) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          if (wr_req_i[w]) begin
            m_data[w][wr_data_i.idx][wr_data_i.off[OFF_WIDTH-1:BYTE_OFF_WIDTH]] = wr_data_i.data;
          end
        end
        wr_ack_at = cyc;
      end
      @(negedge clk_i);
      cl_wr_vld_i = 1'b0;
      rd_req_i    = rd_req_i & ~rd_took;
      if (wr_took) begin
        wr_req_i = '0;
      end
      cyc++;
    end
  endtask

  ////////////////////////////////////////
  // result checker
  ////////////////////////////////////////

  // the late tag goes out in the result cycle and outputs are sampled 5 ns later
  initial begin : compare_results
    pend_t e;
    rd_tag_i = '0;
    forever begin
      @(negedge clk_i);
      if (n_checked < pend_q.size()) begin
        e = pend_q[n_checked];
        n_checked++;
        rd_tag_i[e.port] = e.tag;
        #5;
        check_val("rd_hit_oh_o", 32'(rd_hit_oh_o), 32'(e.exp.hit));
        check_val("rd_vld_bits_o", 32'(rd_vld_bits_o), 32'(e.exp.vld));
        check_val("rd_data_o", rd_data_o, e.exp.data);
      end else begin
        #5;
        check_val("rd_hit_oh_o without read", 32'(rd_hit_oh_o), 32'd0);
      end
    end
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin : stimulus
    logic [TAG_WIDTH-1:0] t;
    int                   wait_cnt;
    void'($urandom(33));
    rst_ni        = 1'b0;
    rd_req_i      = '0;
    rd_req_data_i = '0;
    cl_wr_vld_i   = 1'b0;
    cl_wr_i       = '0;
    wr_req_i      = '0;
    wr_data_i     = '0;
    tag_of_port   = '0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // fill every set of both ways with tags whose msb tells the ways apart
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        t = {w[0], (TAG_WIDTH-1)'($urandom())};
        set_refill(NUM_WAYS'(1 << w), t, s, NUM_WAYS'(1 << w));
        run_requests();
      end
    end
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        for (int b = 0; b < NUM_BANKS; b++) begin
          set_read((s + b) % int'(NUM_RD_PORTS), s, b, m_tag[w][s], 1'b0);
          run_requests();
        end
      end
    end

    // misses on a wrong tag and on a line refilled as invalid
    set_read(0, 6, 1, m_tag[0][6] ^ 8'h40, 1'b0);
    run_requests();
    t = m_tag[1][5];
    set_refill(2'b10, t, 5, 2'b00);
    run_requests();
    set_read(1, 5, 2, t, 1'b0);
    run_requests();
    set_read(0, 5, 2, m_tag[0][5], 1'b0);
    run_requests();

    // word write followed by reads of the whole line
    set_word_write(0, 3, 2, $urandom());
    run_requests();
    for (int b = 0; b < NUM_BANKS; b++) begin
      set_read(1, 3, b, m_tag[0][3], 1'b0);
      run_requests();
    end

    // equal priority alternates
    grant_log.delete();
    // a lone port 0 read leaves the pointer on port 1
    set_read(0, 3, 0, m_tag[0][3], 1'b0);
    run_requests();
    for (int r = 0; r < 3; r++) begin
      set_read(0, r, r, m_tag[0][r], 1'b0);
      set_read(1, r + 8, r + 1, m_tag[1][r + 8], 1'b0);
      run_requests();
      check_val("ack cycles of both ports", 32'(rd_ack_at[0] + rd_ack_at[1]), 32'd1);
    end
    for (int i = 1; i < grant_log.size(); i++) begin
      check_val("grant alternation", 32'(grant_log[i] != grant_log[i - 1]), 32'd1);
    end

    // high priority goes first for either pointer value
    for (int hp = 0; hp < NUM_RD_PORTS; hp++) begin
      repeat (2) begin
        grant_log.delete();
        set_read(0, 1, 0, m_tag[0][1], hp == 0);
        set_read(1, 2, 3, m_tag[1][2], hp == 1);
        run_requests();
        check_val("first grant to high priority", 32'(grant_log[0]), 32'(hp));
      end
    end

    // word write next to a read in a different bank and then in the same bank
    set_read(0, 2, 1, m_tag[0][2], 1'b0);
    set_word_write(1, 7, 3, $urandom());
    run_requests();
    check_val("rd ack cycle, banks differ", 32'(rd_ack_at[0]), 32'd0);
    check_val("wr ack cycle, banks differ", 32'(wr_ack_at), 32'd0);
    set_read(0, 2, 1, m_tag[0][2], 1'b0);
    set_word_write(1, 9, 1, $urandom());
    run_requests();
    check_val("rd ack cycle, same bank", 32'(rd_ack_at[0]), 32'd0);
    check_val("wr ack cycle, same bank", 32'(wr_ack_at), 32'd1);

    // refill holds off both the read and the word write
    t = {1'b0, (TAG_WIDTH-1)'($urandom())};
    set_refill(2'b01, t, 4, 2'b01);
    set_read(1, 4, 0, t, 1'b0);
    set_word_write(0, 11, 2, $urandom());
    run_requests();
    check_val("rd ack cycle after refill", 32'(rd_ack_at[1]), 32'd1);
    check_val("wr ack cycle after refill", 32'(wr_ack_at), 32'd1);

    set_read(0, 7, 3, m_tag[1][7], 1'b0);
    run_requests();
    set_read(1, 9, 1, m_tag[1][9], 1'b0);
    run_requests();
    set_read(0, 11, 2, m_tag[0][11], 1'b0);
    run_requests();

    // let the checker catch up
    wait_cnt = 0;
    while (n_checked < pend_q.size()) begin
      if (wait_cnt >= TIMEOUT_CYCLES) begin
        stop_with_failure("timeout while waiting for the last read results");
      end
      @(negedge clk_i);
      wait_cnt++;
    end
    @(negedge clk_i);
    #10;
    if (n_checked != pend_q.size() || pend_q.size() == 0) begin
      stop_with_failure("read results were not all checked at the end of the run");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
